/* rtl/pcs_rx_consts.svh */
/*
 * 1000BASE-X receive PCS constants
 * Special code-group byte values and synchronization thresholds
 */
`ifndef PCS_RX_CONSTS_SVH
`define PCS_RX_CONSTS_SVH

// ----------------------------------------
// Control code groups (K flag set)
// ----------------------------------------
`define PCS_K28_5 8'hBC
`define PCS_K27_7 8'hFB
`define PCS_K29_7 8'hFD
`define PCS_K23_7 8'hF7

// Second byte of /I1/ and /I2/
`define PCS_D5_6  8'hC5
`define PCS_D16_2 8'h50
// Second byte of /C1/ and /C2/
`define PCS_D21_5 8'hB5
`define PCS_D2_2  8'h42

// Even-aligned commas needed to declare sync
`define PCS_SYNC_ACQ_COMMAS 3
// Consecutive invalid groups that drop sync
`define PCS_SYNC_LOSS_ERRS  4

`endif

/* rtl/pcs_code_pkg.sv */
/*
 * Code-group classification types
 * Kinds that the classifier assigns to each decoded code group
 */
`default_nettype none

package pcs_code_pkg;

  // ----------------------------------------
  // Code-group kind
  // ----------------------------------------
  typedef enum logic [2:0] {
    // Plain data byte
    CG_DATA    = 3'd0,
    // K28.5 comma
    CG_COMMA   = 3'd1,
    // Start of packet, K27.7
    CG_SPD     = 3'd2,
    // End of packet, K29.7
    CG_EPD     = 3'd3,
    // Carrier extend, K23.7
    CG_EXTEND  = 3'd4,
    // Any other control group
    CG_OTHER_K = 3'd5,
    // Code or running disparity error
    CG_ERR     = 3'd6
  } cg_kind_t;

endpackage

`default_nettype wire

/* rtl/pcs_rx_pkg.sv */
/*
 * Receive PCS state types
 * Receive state machine and code-group synchronizer states
 */
`default_nettype none

package pcs_rx_pkg;

  // Receive state machine
  typedef enum logic [2:0] {
    RX_NOFRAME = 3'd0,
    RX_COMMA   = 3'd1,
    RX_CR3     = 3'd2,
    RX_CR4     = 3'd3,
    RX_PAYLOAD = 3'd4,
    RX_EXTEND  = 3'd5
  } rx_state_t;

  // Code-group synchronizer
  typedef enum logic [1:0] {
    SYNC_LOST = 2'd0,
    SYNC_ACQ  = 2'd1,
    SYNC_OK   = 2'd2
  } sync_state_t;

endpackage

`default_nettype wire

/* rtl/code_group_if.sv */
/*
 * Classified code group
 * One group per clock from the classifier to the receive FSM
 */
`default_nettype none

interface code_group_if
  import pcs_code_pkg::*;
();

  // Decoded byte
  logic [7:0] data;
  // Kind derived from byte, K flag and errors
  cg_kind_t   kind;
  // Group sits on an even alignment
  logic       even;
  // D5.6 or D16.2 received as data
  logic       is_idle;
  // D21.5 or D2.2 received as data
  logic       is_cfg;

  // Classifier side
  modport producer (output data, kind, even, is_idle, is_cfg);

  // Receive FSM side
  modport consumer (input data, kind, even, is_idle, is_cfg);

endinterface

`default_nettype wire

/* rtl/pcs_sync_detect.sv */
/*
 * Code-group synchronization detector
 * Acquires sync on even-aligned commas, drops it on repeated errors,
 * and tracks even/odd alignment of the incoming groups
 */
`default_nettype none
`include "pcs_rx_consts.svh"

module pcs_sync_detect import pcs_rx_pkg::*; (
  input  wire       clk,
  input  wire       rst,
  input  wire       en_i,
  input  wire       los_i,
  input  wire       k_i,
  input  wire       err_i,
  input  wire [7:0] data_i,
  output logic      synced_o,
  output logic      even_o
);

  localparam int ACQ_W  = $clog2(`PCS_SYNC_ACQ_COMMAS + 1);
  localparam int LOSS_W = $clog2(`PCS_SYNC_LOSS_ERRS + 1);
  // Count values at which the next event completes the threshold
  localparam logic [ACQ_W-1:0]  ACQ_LAST  = ACQ_W'(`PCS_SYNC_ACQ_COMMAS - 1);
  localparam logic [LOSS_W-1:0] LOSS_LAST = LOSS_W'(`PCS_SYNC_LOSS_ERRS - 1);

  sync_state_t       state_q;
  logic [ACQ_W-1:0]  comma_cnt_q;
  logic [LOSS_W-1:0] err_cnt_q;
  logic              even_q;
  logic              is_comma;
  logic              invalid;

  assign is_comma = k_i && !err_i && (data_i == `PCS_K28_5);

  // Alignment of the group now at the input
  // A comma while unsynced realigns to even
  assign even_o  = (state_q == SYNC_LOST && is_comma) ? 1'b1 : ~even_q;
  // Odd comma counts as invalid
  assign invalid = err_i || (is_comma && !even_o);

  assign synced_o = (state_q == SYNC_OK);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= SYNC_LOST;
      comma_cnt_q <= '0;
      err_cnt_q   <= '0;
      even_q      <= 1'b0;
    end else begin
      even_q <= even_o;
      if (!en_i || los_i) begin
        state_q     <= SYNC_LOST;
        comma_cnt_q <= '0;
        err_cnt_q   <= '0;
      end else begin
        case (state_q)
          SYNC_LOST: begin
            // First comma starts acquisition
            if (is_comma) begin
              state_q     <= SYNC_ACQ;
              comma_cnt_q <= ACQ_W'(1);
            end
          end
          SYNC_ACQ: begin
            if (invalid) begin
              state_q     <= SYNC_LOST;
              comma_cnt_q <= '0;
            end else if (is_comma) begin
              if (comma_cnt_q == ACQ_LAST) begin
                state_q   <= SYNC_OK;
                err_cnt_q <= '0;
              end else begin
                comma_cnt_q <= comma_cnt_q + ACQ_W'(1);
              end
            end
          end
          SYNC_OK: begin
            // Only consecutive invalid groups count
            if (!invalid) begin
              err_cnt_q <= '0;
            end else if (err_cnt_q == LOSS_LAST) begin
              state_q     <= SYNC_LOST;
              comma_cnt_q <= '0;
              err_cnt_q   <= '0;
            end else begin
              err_cnt_q <= err_cnt_q + LOSS_W'(1);
            end
          end
          default: state_q <= SYNC_LOST;
        endcase
      end
    end
  end

  // Sync may only be declared while the PCS is enabled
  a_sync_needs_en: assert property (@(posedge clk) disable iff (rst)
    $rose(synced_o) |-> $past(en_i));

endmodule

`default_nettype wire

/* rtl/code_group_classifier.sv */
/*
 * Code-group classifier
 * Registers each decoded group and tags it with kind and alignment
 */
`default_nettype none
`include "pcs_rx_consts.svh"

module code_group_classifier import pcs_code_pkg::*; (
  input  wire            clk,
  input  wire            rst,
  input  wire [7:0]      data_i,
  input  wire            k_i,
  input  wire            err_code_i,
  input  wire            err_rdisp_i,
  input  wire            even_i,
  code_group_if.producer cg
);

  cg_kind_t kind_d;
  logic     is_data;

  // Any decode error overrides the byte value
  always_comb begin
    if (err_code_i || err_rdisp_i) begin
      kind_d = CG_ERR;
    end else if (!k_i) begin
      kind_d = CG_DATA;
    end else begin
      case (data_i)
        `PCS_K28_5: kind_d = CG_COMMA;
        `PCS_K27_7: kind_d = CG_SPD;
        `PCS_K29_7: kind_d = CG_EPD;
        `PCS_K23_7: kind_d = CG_EXTEND;
        default:    kind_d = CG_OTHER_K;
      endcase
    end
  end

  assign is_data = (kind_d == CG_DATA);

  // Byte and alignment pass straight through the register
  always_ff @(posedge clk) begin
    cg.data <= data_i;
    cg.even <= even_i;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cg.kind    <= CG_ERR;
      cg.is_idle <= 1'b0;
      cg.is_cfg  <= 1'b0;
    end else begin
      cg.kind    <= kind_d;
      cg.is_idle <= is_data && (data_i == `PCS_D5_6 || data_i == `PCS_D16_2);
      cg.is_cfg  <= is_data && (data_i == `PCS_D21_5 || data_i == `PCS_D2_2);
    end
  end

  // A decode error on the input leaves an error group with no idle or config tag
  a_err_not_tagged: assert property (@(posedge clk) disable iff (rst)
    (err_code_i || err_rdisp_i) |=> (cg.kind == CG_ERR) && !(cg.is_idle || cg.is_cfg));

endmodule

`default_nettype wire

/* rtl/pcs_rx_fsm.sv */
/*
 * Receive PCS state machine
 * Strips delimiters and carrier extend, drives the GMII byte stream
 * and captures autonegotiation config words from /C/ ordered sets
 */
`default_nettype none

module pcs_rx_fsm import pcs_code_pkg::*, pcs_rx_pkg::*; (
  input  wire            clk,
  input  wire            rst,
  input  wire            en_i,
  input  wire            synced_i,
  code_group_if.consumer cg,
  input  wire            lacr_en_i,
  output logic [7:0]     gmii_data_o,
  output logic           gmii_dv_o,
  output logic           gmii_err_o,
  output logic [15:0]    lacr_val_o,
  output logic           lacr_stb_o
);

  rx_state_t   state_q;
  // One-cycle results of the current group
  logic        fwd_vld_q;
  logic        abort_q;
  logic        cfg_stb_q;
  logic [7:0]  fwd_data_q;
  logic [7:0]  cfg_lo_q;
  logic [15:0] cfg_val_q;

  // ----------------------------------------
  // Payload and config byte capture
  // ----------------------------------------
  always_ff @(posedge clk) begin
    fwd_data_q <= cg.data;
    // Low byte arrives on the even group, high byte on the odd one
    if (state_q == RX_CR3) cfg_lo_q <= cg.data;
    if (state_q == RX_CR4) cfg_val_q <= {cg.data, cfg_lo_q};
  end

  // ----------------------------------------
  // Main receive FSM
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= RX_NOFRAME;
      fwd_vld_q <= 1'b0;
      abort_q   <= 1'b0;
      cfg_stb_q <= 1'b0;
    end else begin
      fwd_vld_q <= 1'b0;
      abort_q   <= 1'b0;
      cfg_stb_q <= 1'b0;
      if (!en_i) begin
        state_q <= RX_NOFRAME;
      end else begin
        case (state_q)
          RX_NOFRAME: begin
            // Nothing leaves idle until sync is held
            if (synced_i && cg.kind == CG_COMMA) begin
              state_q <= RX_COMMA;
            end else if (synced_i && cg.kind == CG_SPD && cg.even) begin
              state_q <= RX_PAYLOAD;
            end
          end
          RX_COMMA: begin
            // Second group of /I/ or /C/ must be odd data
            if (cg.kind != CG_DATA || cg.even) begin
              state_q <= RX_NOFRAME;
            end else if (cg.is_cfg) begin
              state_q <= RX_CR3;
            end else if (cg.is_idle) begin
              state_q <= RX_NOFRAME;
            end
          end
          RX_CR3: begin
            // Bad group here drops the whole ordered set
            if (cg.kind == CG_DATA && cg.even) state_q <= RX_CR4;
            else state_q <= RX_NOFRAME;
          end
          RX_CR4: begin
            if (cg.kind == CG_DATA && !cg.even) cfg_stb_q <= lacr_en_i;
            state_q <= RX_NOFRAME;
          end
          RX_PAYLOAD: begin
            if (cg.kind == CG_ERR || !synced_i) begin
              state_q <= RX_NOFRAME;
              abort_q <= 1'b1;
            end else if (cg.kind == CG_DATA) begin
              fwd_vld_q <= 1'b1;
            end else if (cg.kind == CG_EPD) begin
              state_q <= RX_EXTEND;
            end else begin
              // Premature end on any other K group
              abort_q <= 1'b1;
              state_q <= (cg.kind == CG_COMMA) ? RX_COMMA : RX_NOFRAME;
            end
          end
          RX_EXTEND: begin
            if (cg.kind == CG_COMMA) begin
              state_q <= RX_COMMA;
            end else if (cg.kind != CG_EXTEND) begin
              abort_q <= 1'b1;
              state_q <= RX_NOFRAME;
            end
          end
          default: state_q <= RX_NOFRAME;
        endcase
      end
    end
  end

  // ----------------------------------------
  // Output stage
  // ----------------------------------------
  always_ff @(posedge clk) begin
    gmii_data_o <= fwd_data_q;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      gmii_dv_o  <= 1'b0;
      gmii_err_o <= 1'b0;
      lacr_stb_o <= 1'b0;
      lacr_val_o <= '0;
    end else begin
      gmii_dv_o  <= fwd_vld_q;
      gmii_err_o <= abort_q;
      lacr_stb_o <= cfg_stb_q;
      // Value holds unless a new word is strobed
      if (cfg_stb_q) lacr_val_o <= cfg_val_q;
    end
  end

  // Frame abort and config strobe come from disjoint states
  a_err_stb_excl: assert property (@(posedge clk) disable iff (rst)
    !(gmii_err_o && lacr_stb_o));

endmodule

`default_nettype wire

/* rtl/pcs_rx_top.sv */
/*
 * 1000BASE-X receive PCS top level
 * Synchronizer, classifier and receive FSM behind plain ports
 */
`default_nettype none

module pcs_rx_top (
  input  wire        clk,
  input  wire        rst,
  // Decoded code groups from the 8b/10b decoder
  input  wire [7:0]  dec_data_i,
  input  wire        dec_is_k_i,
  input  wire        dec_err_code_i,
  input  wire        dec_err_rdisp_i,
  input  wire        dec_err_los_i,
  // Control
  input  wire        pcs_en_i,
  input  wire        lacr_en_i,
  // GMII side
  output logic [7:0] gmii_data_o,
  output logic       gmii_dv_o,
  output logic       gmii_err_o,
  output wire        rcr_los_o,
  output logic [15:0] lacr_val_o,
  output logic       lacr_stb_o
);

  logic synced;
  logic even;
  logic dec_err;

  code_group_if cg_if ();

  // Either decode error spoils the group for sync
  assign dec_err   = dec_err_code_i | dec_err_rdisp_i;
  assign rcr_los_o = dec_err_los_i;

  pcs_sync_detect u_sync (
    .clk(clk), .rst(rst), .en_i(pcs_en_i), .los_i(dec_err_los_i), .k_i(dec_is_k_i),
    .err_i(dec_err), .data_i(dec_data_i), .synced_o(synced), .even_o(even));

  code_group_classifier u_classify (
    .clk(clk), .rst(rst), .data_i(dec_data_i), .k_i(dec_is_k_i),
    .err_code_i(dec_err_code_i), .err_rdisp_i(dec_err_rdisp_i), .even_i(even),
    .cg(cg_if.producer));

  pcs_rx_fsm u_fsm (
    .clk(clk), .rst(rst), .en_i(pcs_en_i), .synced_i(synced), .cg(cg_if.consumer),
    .lacr_en_i(lacr_en_i), .gmii_data_o(gmii_data_o), .gmii_dv_o(gmii_dv_o),
    .gmii_err_o(gmii_err_o), .lacr_val_o(lacr_val_o), .lacr_stb_o(lacr_stb_o));

endmodule

`default_nettype wire

/* sim/tb_clk_gen.sv */
/*
 * Testbench clock source
 * Free-running 10 ns clock
 */
`default_nettype none

module tb_clk_gen (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  initial clk = 1'b0;

  // Half period of 5 ns
  always #5 clk = ~clk;

endmodule

`default_nettype wire

/* sim/tb_pcs_rx_top.sv */
/*
 * Testbench for the 1000BASE-X receive PCS
 * Drives a queue of decoded code groups, predicts GMII bytes, abort
 * pulses and config words from the PCS rules, and compares them
 */
`default_nettype none
`include "pcs_rx_consts.svh"

module tb_pcs_rx_top import pcs_code_pkg::*, pcs_rx_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int FAULT_NONE    = 0;
  localparam int FAULT_CODE    = 1;
  localparam int FAULT_STRAY_K = 2;
  localparam int FAULT_TAIL    = 3;

  // One decoded code group plus the control levels that go with it
  typedef struct packed {
    logic [7:0] data;
    logic       k;
    logic       err_code;
    logic       err_rdisp;
    logic       los;
    logic       en;
    logic       lacr;
  } group_t;

  logic        clk;
  logic        rst;
  logic [7:0]  dec_data_i;
  logic        dec_is_k_i;
  logic        dec_err_code_i;
  logic        dec_err_rdisp_i;
  logic        dec_err_los_i;
  logic        pcs_en_i;
  logic        lacr_en_i;
  logic [7:0]  gmii_data_o;
  logic        gmii_dv_o;
  logic        gmii_err_o;
  logic        rcr_los_o;
  logic [15:0] lacr_val_o;
  logic        lacr_stb_o;

  group_t      stim_q[$];
  logic [7:0]  exp_bytes[$];
  logic [15:0] exp_words[$];
  int          exp_errs = 0;
  int          err_seen = 0;
  logic [15:0] last_word = '0;
  logic        stim_ready = 1'b0;
  // Control levels applied to groups as they are queued
  logic        cur_en;
  logic        cur_los;
  logic        cur_lacr;

  tb_clk_gen u_clk_gen (.clk(clk));

  pcs_rx_top UUT (
    .clk(clk), .rst(rst), .dec_data_i(dec_data_i), .dec_is_k_i(dec_is_k_i),
    .dec_err_code_i(dec_err_code_i), .dec_err_rdisp_i(dec_err_rdisp_i),
    .dec_err_los_i(dec_err_los_i), .pcs_en_i(pcs_en_i), .lacr_en_i(lacr_en_i),
    .gmii_data_o(gmii_data_o), .gmii_dv_o(gmii_dv_o), .gmii_err_o(gmii_err_o),
    .rcr_los_o(rcr_los_o), .lacr_val_o(lacr_val_o), .lacr_stb_o(lacr_stb_o));

  task automatic stop_on_failure(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  // ----------------------------------------
  // Stimulus construction
  // ----------------------------------------
  task automatic push_group(input logic [7:0] data, input logic k,
                            input logic err_code, input logic err_rdisp);
    group_t g;
    g.data      = data;
    g.k         = k;
    g.err_code  = err_code;
    g.err_rdisp = err_rdisp;
    g.los       = cur_los;
    g.en        = cur_en;
    g.lacr      = cur_lacr;
    stim_q.push_back(g);
  endtask

  // /I1/ first, then /I2/ pairs
  task automatic add_idle(input int pairs);
    for (int i = 0; i < pairs; i++) begin
      push_group(`PCS_K28_5, 1'b1, 1'b0, 1'b0);
      push_group((i == 0) ? `PCS_D5_6 : `PCS_D16_2, 1'b0, 1'b0, 1'b0);
    end
  endtask

  // /C1/ or /C2/ with the word sent low byte first
  task automatic add_cfg(input logic [15:0] word, input logic second);
    push_group(`PCS_K28_5, 1'b1, 1'b0, 1'b0);
    push_group(second ? `PCS_D2_2 : `PCS_D21_5, 1'b0, 1'b0, 1'b0);
    push_group(word[7:0], 1'b0, 1'b0, 1'b0);
    push_group(word[15:8], 1'b0, 1'b0, 1'b0);
  endtask

  task automatic add_frame(input int fault);
    int len;
    int pos;
    int ext;
    len = $urandom_range(64, (fault == FAULT_NONE) ? 1 : 2);
    pos = $urandom_range(len - 1, 1);
    // Extend count keeps the closing comma on an even group
    ext = len % 2;
    if (ext == 0 && $urandom_range(1, 0) == 1) ext = 2;
    if (fault == FAULT_TAIL && ext == 0) ext = 2;
    push_group(`PCS_K27_7, 1'b1, 1'b0, 1'b0);
    for (int i = 0; i < len; i++) begin
      if (i == pos && fault == FAULT_CODE) push_group(8'($urandom()), 1'b0, 1'b1, 1'b0);
      else if (i == pos && fault == FAULT_STRAY_K) push_group(8'h1C, 1'b1, 1'b0, 1'b0);
      else push_group(8'($urandom()), 1'b0, 1'b0, 1'b0);
    end
    push_group(`PCS_K29_7, 1'b1, 1'b0, 1'b0);
    for (int j = 0; j < ext; j++) begin
      // Plain data where only extend or comma may follow
      if (j == 0 && fault == FAULT_TAIL) push_group(8'h4A, 1'b0, 1'b0, 1'b0);
      else push_group(`PCS_K23_7, 1'b1, 1'b0, 1'b0);
    end
    add_idle(1);
  endtask

  task automatic build_stimulus();
    cur_en   = 1'b1;
    cur_los  = 1'b0;
    cur_lacr = 1'b1;
    // Frame before sync, then acquisition
    add_frame(FAULT_NONE);
    add_idle(8);
    repeat (4) begin
      add_frame(FAULT_NONE);
      add_idle(2);
    end
    add_frame(FAULT_CODE);
    add_idle(2);
    add_frame(FAULT_STRAY_K);
    add_idle(2);
    add_frame(FAULT_TAIL);
    add_idle(2);
    // Config words, strobed and then masked
    add_cfg(16'($urandom()), 1'b0);
    add_cfg(16'($urandom()), 1'b1);
    add_idle(2);
    cur_lacr = 1'b0;
    add_idle(1);
    add_cfg(16'($urandom()), 1'b0);
    add_idle(2);
    cur_lacr = 1'b1;
    add_idle(1);
    // Error burst drops sync
    push_group(8'h00, 1'b0, 1'b1, 1'b0);
    push_group(8'h00, 1'b0, 1'b0, 1'b1);
    push_group(8'h00, 1'b0, 1'b1, 1'b0);
    push_group(8'h00, 1'b0, 1'b0, 1'b1);
    add_frame(FAULT_NONE);
    add_idle(6);
    add_frame(FAULT_NONE);
    add_idle(2);
    // Loss of signal
    cur_los = 1'b1;
    add_idle(3);
    add_frame(FAULT_NONE);
    cur_los = 1'b0;
    add_idle(6);
    add_frame(FAULT_NONE);
    add_idle(2);
    // PCS disabled
    cur_en = 1'b0;
    add_idle(3);
    add_frame(FAULT_NONE);
    cur_en = 1'b1;
    add_idle(6);
    add_frame(FAULT_NONE);
    add_idle(4);
  endtask

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic cg_kind_t kind_of(input group_t g);
    if (g.err_code || g.err_rdisp) return CG_ERR;
    if (!g.k) return CG_DATA;
    case (g.data)
      `PCS_K28_5: return CG_COMMA;
      `PCS_K27_7: return CG_SPD;
      `PCS_K29_7: return CG_EPD;
      `PCS_K23_7: return CG_EXTEND;
      default:    return CG_OTHER_K;
    endcase
  endfunction

  function automatic void predict_outputs();
    sync_state_t sync_st;
    rx_state_t   rx_st;
    cg_kind_t    kind;
    group_t      g;
    group_t      nx;
    int          comma_cnt;
    int          bad_cnt;
    logic        even;
    logic        prev_even;
    logic        comma;
    logic        invalid;
    logic        synced;
    logic        idle_byte;
    logic        cfg_byte;
    logic [7:0]  cfg_lo;
    sync_st   = SYNC_LOST;
    rx_st     = RX_NOFRAME;
    comma_cnt = 0;
    bad_cnt   = 0;
    prev_even = 1'b0;
    cfg_lo    = '0;
    foreach (stim_q[i]) begin
      g  = stim_q[i];
      // State machine sees enable and config enable one cycle later
      nx = (i + 1 < stim_q.size()) ? stim_q[i + 1] : g;
      kind      = kind_of(g);
      comma     = (kind == CG_COMMA);
      idle_byte = (kind == CG_DATA) && (g.data == `PCS_D5_6 || g.data == `PCS_D16_2);
      cfg_byte  = (kind == CG_DATA) && (g.data == `PCS_D21_5 || g.data == `PCS_D2_2);
      even      = (sync_st == SYNC_LOST && comma) ? 1'b1 : !prev_even;
      prev_even = even;
      invalid   = (kind == CG_ERR) || (comma && !even);

      // Synchronization
      if (!g.en || g.los) begin
        sync_st   = SYNC_LOST;
        comma_cnt = 0;
        bad_cnt   = 0;
      end else if (sync_st == SYNC_LOST) begin
        if (comma) begin
          sync_st   = SYNC_ACQ;
          comma_cnt = 1;
        end
      end else if (sync_st == SYNC_ACQ) begin
        if (invalid) begin
          sync_st = SYNC_LOST;
        end else if (comma) begin
          comma_cnt++;
          if (comma_cnt == `PCS_SYNC_ACQ_COMMAS) begin
            sync_st = SYNC_OK;
            bad_cnt = 0;
          end
        end
      end else if (!invalid) begin
        bad_cnt = 0;
      end else begin
        bad_cnt++;
        if (bad_cnt == `PCS_SYNC_LOSS_ERRS) sync_st = SYNC_LOST;
      end
      synced = (sync_st == SYNC_OK);

      // Receive FSM
      if (!nx.en) begin
        rx_st = RX_NOFRAME;
      end else begin
        case (rx_st)
          RX_NOFRAME: begin
            if (synced && comma) rx_st = RX_COMMA;
            else if (synced && kind == CG_SPD && even) rx_st = RX_PAYLOAD;
          end
          RX_COMMA: begin
            if (kind != CG_DATA || even) rx_st = RX_NOFRAME;
            else if (cfg_byte) rx_st = RX_CR3;
            else if (idle_byte) rx_st = RX_NOFRAME;
          end
          RX_CR3: begin
            cfg_lo = g.data;
            rx_st  = (kind == CG_DATA && even) ? RX_CR4 : RX_NOFRAME;
          end
          RX_CR4: begin
            if (kind == CG_DATA && !even && nx.lacr) exp_words.push_back({g.data, cfg_lo});
            rx_st = RX_NOFRAME;
          end
          RX_PAYLOAD: begin
            if (kind == CG_ERR || !synced) begin
              exp_errs++;
              rx_st = RX_NOFRAME;
            end else if (kind == CG_DATA) begin
              exp_bytes.push_back(g.data);
            end else if (kind == CG_EPD) begin
              rx_st = RX_EXTEND;
            end else begin
              exp_errs++;
              rx_st = comma ? RX_COMMA : RX_NOFRAME;
            end
          end
          default: begin
            if (comma) begin
              rx_st = RX_COMMA;
            end else if (kind != CG_EXTEND) begin
              exp_errs++;
              rx_st = RX_NOFRAME;
            end
          end
        endcase
      end
    end
  endfunction

  // ----------------------------------------
  // Reset and drive
  // ----------------------------------------
  initial begin : drive_stimulus
    rst             <= 1'b1;
    dec_data_i      <= '0;
    dec_is_k_i      <= 1'b0;
    dec_err_code_i  <= 1'b0;
    dec_err_rdisp_i <= 1'b0;
    dec_err_los_i   <= 1'b0;
    pcs_en_i        <= 1'b0;
    lacr_en_i       <= 1'b0;
    void'($urandom(32'h2));
    build_stimulus();
    stim_ready = 1'b1;
    predict_outputs();
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    // First group lands on the edge that releases reset
    foreach (stim_q[i]) begin
      dec_data_i      <= stim_q[i].data;
      dec_is_k_i      <= stim_q[i].k;
      dec_err_code_i  <= stim_q[i].err_code;
      dec_err_rdisp_i <= stim_q[i].err_rdisp;
      dec_err_los_i   <= stim_q[i].los;
      pcs_en_i        <= stim_q[i].en;
      lacr_en_i       <= stim_q[i].lacr;
      @(posedge clk);
    end
    // Pipeline is 3 cycles deep
    repeat (5) @(posedge clk);
    assert (exp_bytes.size() == 0) else stop_on_failure(
      $sformatf("%0d expected GMII bytes never appeared", exp_bytes.size()));
    assert (err_seen == exp_errs) else stop_on_failure(
      $sformatf("** Error at %0t ns: gmii_err_o pulses %0d, expected %0d",
                $time, err_seen, exp_errs));
    assert (exp_words.size() == 0) else stop_on_failure(
      $sformatf("%0d expected config words were never strobed", exp_words.size()));
    $display("Finished with no errors");
    $finish;
  end

  // ----------------------------------------
  // Output comparison, mid-cycle
  // ----------------------------------------
  always @(negedge clk) begin : compare_outputs
    logic [7:0]  exp_byte;
    logic [15:0] exp_word;
    if (!rst) begin
      assert (rcr_los_o === dec_err_los_i) else stop_on_failure(
        $sformatf("** Error at %0t ns: rcr_los_o = %b, expected %b",
                  $time, rcr_los_o, dec_err_los_i));
      if (gmii_dv_o) begin
        assert (exp_bytes.size() > 0) else stop_on_failure(
          $sformatf("gmii_dv_o went high at %0t ns with no byte expected", $time));
        exp_byte = exp_bytes.pop_front();
        assert (gmii_data_o == exp_byte) else stop_on_failure(
          $sformatf("** Error at %0t ns: gmii_data_o = 8'h%02h, expected 8'h%02h",
                    $time, gmii_data_o, exp_byte));
      end
      if (gmii_err_o) begin
        err_seen++;
        assert (err_seen <= exp_errs) else stop_on_failure(
          $sformatf("gmii_err_o pulsed at %0t ns beyond the %0d expected aborts",
                    $time, exp_errs));
      end
      if (lacr_stb_o) begin
        assert (exp_words.size() > 0) else stop_on_failure(
          $sformatf("lacr_stb_o pulsed at %0t ns with no config word expected", $time));
        exp_word  = exp_words.pop_front();
        last_word = exp_word;
      end
      // Value holds between strobes
      assert (lacr_val_o == last_word) else stop_on_failure(
        $sformatf("** Error at %0t ns: lacr_val_o = 16'h%04h, expected 16'h%04h",
                  $time, lacr_val_o, last_word));
    end
  end

  initial begin : watchdog
    wait (stim_ready);
    #(stim_q.size() * 10 + 1000);
    stop_on_failure("Timeout: the run did not finish within its time limit");
  end

endmodule

`default_nettype wire

/* pcs_rx_top.f */
+incdir+rtl
rtl/pcs_code_pkg.sv
rtl/pcs_rx_pkg.sv
rtl/code_group_if.sv
rtl/pcs_sync_detect.sv
rtl/code_group_classifier.sv
rtl/pcs_rx_fsm.sv
rtl/pcs_rx_top.sv
sim/tb_clk_gen.sv
sim/tb_pcs_rx_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it; exit status is the test result
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_pcs_rx_top -f pcs_rx_top.f \
  && ./obj_dir/Vtb_pcs_rx_top \
  || exit 1
